// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_seg_display_top
FILELIST  ?= seg_display_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure."; exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result."; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_seg_display_top.sv ====
`timescale 1ns/1ps

module tb_seg_display_top;

	import seg_axi_pkg::*;
	import seg_disp_pkg::*;

	localparam int wait_limit = 64;
	localparam int num_random = 400;

	// Standard hex glyphs, active low with segment a in bit 0.
	localparam logic [6:0] ref_glyph [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	logic			clk;
	logic			rst;
	axil_req_t		axil_i;
	axil_rsp_t		axil_o;
	logic [6:0]		hex_seg [num_digits];

	logic [31:0]	rng_state;
	logic [4:0]		model_reg [num_digits];	// Blank in bit 4, value in bits 3:0.
	int				mismatches;
	int				timeouts;
	logic			timed_out;

	seg_display_top UUT (
		.clk	(clk),
		.rst	(rst),
		.axil_i	(axil_i),
		.axil_o	(axil_o),
		.hex_o	(hex_seg)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// The upper half of the LCG state is the better distributed one.
	function automatic int unsigned rand_below(int unsigned n);
		logic [31:0] r;
		r = next_rand();
		return {16'd0, r[31:16]} % n;
	endfunction

	function automatic logic [6:0] expected_hex(logic [4:0] r);
		if (r[4])
			return 7'b1111111;
		return ref_glyph[r[3:0]];
	endfunction

	task automatic check_value(string name, logic [31:0] exp_val, logic [31:0] act_val);
		if (exp_val !== act_val) begin
			$display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
			mismatches++;
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout: %s did not happen within %0d cycles.", what, wait_limit);
		timeouts++;
		timed_out = 1'b1;
	endtask

	task automatic check_hex(string name);
		for (int i = 0; i < num_digits; i++) begin
			check_value($sformatf("%s hex%0d", name, i),
				32'(expected_hex(model_reg[i])), 32'(hex_seg[i]));
		end
	endtask

	task automatic write_word(logic [4:0] addr, logic [31:0] data, logic [3:0] strb,
			logic together);
		int			cycles;
		int			gap;
		int			stall;
		logic		aw_done;
		logic		w_done;
		logic		w_sent;
		logic		aw_fire;
		logic		w_fire;
		logic		b_fire;
		logic		done;
		logic [2:0]	idx;
		logic		mapped;
		logic [1:0]	exp_resp;

		idx      = addr[4:2];
		mapped   = idx < 3'd6;
		exp_resp = mapped ? resp_okay : resp_slverr;
		gap      = int'(rand_below(4));
		stall    = int'(rand_below(5));
		aw_done  = 1'b0;
		w_done   = 1'b0;
		w_sent   = together;
		cycles   = 0;

		@(posedge clk);
		axil_i.aw_valid <= 1'b1;
		axil_i.aw_addr  <= addr;
		if (together) begin
			axil_i.w_valid <= 1'b1;
			axil_i.w_data  <= data;
			axil_i.w_strb  <= strb;
		end
		while (!(aw_done && w_done) && cycles < wait_limit) begin
			@(negedge clk);
			aw_fire = axil_i.aw_valid && axil_o.aw_ready;
			w_fire  = axil_i.w_valid && axil_o.w_ready;
			@(posedge clk);
			if (aw_fire) begin
				aw_done = 1'b1;
				axil_i.aw_valid <= 1'b0;
			end
			if (w_fire) begin
				w_done = 1'b1;
				axil_i.w_valid <= 1'b0;
			end
			// Data follows its address after a random gap.
			if (aw_done && !w_sent) begin
				if (gap == 0) begin
					axil_i.w_valid <= 1'b1;
					axil_i.w_data  <= data;
					axil_i.w_strb  <= strb;
					w_sent = 1'b1;
				end else begin
					gap--;
				end
			end
			cycles++;
		end
		if (!(aw_done && w_done)) begin
			report_timeout("write address and data acceptance");
			return;
		end

		cycles = 0;
		@(negedge clk);
		while (!axil_o.b_valid && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!axil_o.b_valid) begin
			report_timeout("write response valid");
			return;
		end
		check_value("write b_valid latency", 32'd0, 32'(cycles));
		check_value("write b_resp", 32'(exp_resp), 32'(axil_o.b_resp));
		if (mapped && strb[0])
			model_reg[idx] = data[4:0];

		// The digit loads on the edge that closes the first response cycle.
		@(posedge clk);
		axil_i.b_ready <= (stall == 0);
		@(negedge clk);
		check_hex("write segments");

		done   = 1'b0;
		cycles = 0;
		while (!done && cycles < wait_limit) begin
			check_value("write b_valid hold", 32'd1, 32'(axil_o.b_valid));
			check_value("write b_resp hold", 32'(exp_resp), 32'(axil_o.b_resp));
			b_fire = axil_i.b_ready && axil_o.b_valid;
			@(posedge clk);
			if (b_fire) begin
				axil_i.b_ready <= 1'b0;
				done = 1'b1;
			end else begin
				if (stall > 0)
					stall--;
				axil_i.b_ready <= (stall == 0);
			end
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			report_timeout("write response handshake");
			return;
		end
		check_value("write b_valid drop", 32'd0, 32'(axil_o.b_valid));
		check_hex("write settled");
	endtask

	task automatic read_word(logic [4:0] addr);
		int				cycles;
		int				stall;
		logic			ar_fire;
		logic			r_fire;
		logic			done;
		logic [2:0]		idx;
		logic [31:0]	exp_data;
		logic [1:0]		exp_resp;

		idx   = addr[4:2];
		stall = int'(rand_below(5));
		if (idx < 3'd6) begin
			exp_data = {27'd0, model_reg[idx]};
			exp_resp = resp_okay;
		end else begin
			exp_data = 32'd0;	// Unmapped words read as zero.
			exp_resp = resp_slverr;
		end

		@(posedge clk);
		axil_i.ar_valid <= 1'b1;
		axil_i.ar_addr  <= addr;
		ar_fire = 1'b0;
		cycles  = 0;
		while (!ar_fire && cycles < wait_limit) begin
			@(negedge clk);
			ar_fire = axil_i.ar_valid && axil_o.ar_ready;
			@(posedge clk);
			if (ar_fire)
				axil_i.ar_valid <= 1'b0;
			cycles++;
		end
		if (!ar_fire) begin
			report_timeout("read address acceptance");
			return;
		end
		axil_i.r_ready <= (stall == 0);

		@(negedge clk);
		check_value("read r_valid latency", 32'd1, 32'(axil_o.r_valid));
		done   = 1'b0;
		cycles = 0;
		while (!done && cycles < wait_limit) begin
			check_value("read r_valid hold", 32'd1, 32'(axil_o.r_valid));
			check_value("read r_data", exp_data, axil_o.r_data);
			check_value("read r_resp", 32'(exp_resp), 32'(axil_o.r_resp));
			r_fire = axil_i.r_ready && axil_o.r_valid;
			@(posedge clk);
			if (r_fire) begin
				axil_i.r_ready <= 1'b0;
				done = 1'b1;
			end else begin
				if (stall > 0)
					stall--;
				axil_i.r_ready <= (stall == 0);
			end
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			report_timeout("read response handshake");
			return;
		end
		check_value("read r_valid drop", 32'd0, 32'(axil_o.r_valid));
		check_hex("read segments");
	endtask

	// One in four accesses goes to an unmapped word.
	task automatic random_transaction();
		logic [2:0]		idx;
		logic [31:0]	data;
		logic [3:0]		strb;

		if (rand_below(4) == 0)
			idx = 3'(6 + rand_below(2));
		else
			idx = 3'(rand_below(6));
		if (rand_below(2) == 0) begin
			read_word({idx, 2'b00});
		end else begin
			data = next_rand();
			strb = 4'(rand_below(16));
			if (rand_below(4) != 0)
				strb[0] = 1'b1;
			write_word({idx, 2'b00}, data, strb, rand_below(2) == 0);
		end
	endtask

	initial begin
		clk        = 1'b0;
		rst        <= 1'b1;
		axil_i     <= '0;
		rng_state  = 32'd44044;
		mismatches = 0;
		timeouts   = 0;
		timed_out  = 1'b0;
		for (int i = 0; i < num_digits; i++)
			model_reg[i] = 5'd0;

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_hex("reset");
		check_value("reset aw_ready", 32'd0, 32'(axil_o.aw_ready));
		check_value("reset w_ready", 32'd0, 32'(axil_o.w_ready));
		check_value("reset b_valid", 32'd0, 32'(axil_o.b_valid));
		check_value("reset ar_ready", 32'd0, 32'(axil_o.ar_ready));
		check_value("reset r_valid", 32'd0, 32'(axil_o.r_valid));

		// Every digit once, then read each back.
		for (int i = 0; i < num_digits && !timed_out; i++)
			write_word(5'(i * 4), 32'(i * 3 + 1), 4'hF, 1'b1);
		for (int i = 0; i < num_digits && !timed_out; i++)
			read_word(5'(i * 4));

		for (int n = 0; n < num_random && !timed_out; n++)
			random_transaction();

		for (int i = 0; i < 8 && !timed_out; i++)
			read_word(5'(i * 4));

		$display("Errors: %0d mismatches, %0d timeouts.", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : tb_seg_display_top

// ==== seg_display_top.f ====
source/seg_axi_pkg.sv
source/seg_disp_pkg.sv
source/seg_axil_slave.sv
source/seg_digit.sv
source/seg_collect.sv
source/seg_display_top.sv
bench/tb_seg_display_top.sv

// ==== source/seg_axi_pkg.sv ====
package seg_axi_pkg;

	// Bus geometry of the configuration port.
	localparam int axi_addr_w = 5;
	localparam int axi_data_w = 32;
	localparam int axi_strb_w = axi_data_w / 8;

	// Response codes.
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Everything the host drives toward the slave.
	typedef struct packed {
		logic						aw_valid;
		logic [axi_addr_w-1:0]		aw_addr;
		logic						w_valid;
		logic [axi_data_w-1:0]		w_data;
		logic [axi_strb_w-1:0]		w_strb;
		logic						b_ready;
		logic						ar_valid;
		logic [axi_addr_w-1:0]		ar_addr;
		logic						r_ready;
	} axil_req_t;

	// Everything the slave drives back to the host.
	typedef struct packed {
		logic						aw_ready;
		logic						w_ready;
		logic						b_valid;
		logic [1:0]					b_resp;
		logic						ar_ready;
		logic						r_valid;
		logic [axi_data_w-1:0]		r_data;
		logic [1:0]					r_resp;
	} axil_rsp_t;

endpackage : seg_axi_pkg

// ==== source/seg_axil_slave.sv ====
`timescale 1ns/1ps

module seg_axil_slave (
	input	logic								clk,
	input	logic								rst,
	input	seg_axi_pkg::axil_req_t				bus_i,
	output	seg_axi_pkg::axil_rsp_t				bus_o,
	output	seg_disp_pkg::wr_cmd_t				wr_cmd_o,
	output	logic [seg_disp_pkg::digit_sel_w-1:0]	rd_sel_o,
	input	logic [seg_axi_pkg::axi_data_w-1:0]		rd_word_i
);

	import seg_axi_pkg::*;
	import seg_disp_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_wdata,
		st_wresp,
		st_rresp,
		st_fault
	} state_t;

	state_t state, nxt_state;

	logic aw_hs, w_hs, b_hs, ar_hs, r_hs;

	logic [axi_addr_w-1:0]	aw_addr_q;
	logic [axi_addr_w-1:0]	ar_addr_q;
	logic [axi_addr_w-1:0]	wr_addr;
	logic [digit_sel_w-1:0]	wr_sel;
	logic					wr_mapped;
	logic					rd_mapped;

	logic					wr_pulse;
	logic [digit_sel_w-1:0]	cmd_idx;
	digit_reg_t				cmd_data;
	logic [1:0]				b_resp_q;

	// Ready and valid outputs follow the state register and the host's valids.
	always_comb begin
		bus_o = '0;
		case (state)
			st_idle: begin
				// A pending read wins over a pending write.
				bus_o.ar_ready = bus_i.ar_valid;
				bus_o.aw_ready = !bus_i.ar_valid && bus_i.aw_valid;
				bus_o.w_ready  = !bus_i.ar_valid && bus_i.aw_valid && bus_i.w_valid;
			end
			st_wdata: begin
				bus_o.w_ready = bus_i.w_valid;
			end
			st_wresp: begin
				bus_o.b_valid = 1'b1;
				bus_o.b_resp  = b_resp_q;
			end
			st_rresp: begin
				bus_o.r_valid = 1'b1;
				bus_o.r_data  = rd_mapped ? rd_word_i : '0;
				bus_o.r_resp  = rd_mapped ? resp_okay : resp_slverr;
			end
			default: begin
				bus_o = '0;
			end
		endcase
	end

	assign aw_hs = bus_i.aw_valid && bus_o.aw_ready;
	assign w_hs  = bus_i.w_valid && bus_o.w_ready;
	assign b_hs  = bus_i.b_ready && bus_o.b_valid;
	assign ar_hs = bus_i.ar_valid && bus_o.ar_ready;
	assign r_hs  = bus_i.r_ready && bus_o.r_valid;

	always_comb begin
		nxt_state = state;
		case (state)
			st_idle: begin
				if (ar_hs)
					nxt_state = st_rresp;
				else if (w_hs)
					nxt_state = st_wresp;	// Address and data came together.
				else if (aw_hs)
					nxt_state = st_wdata;
			end
			st_wdata: begin
				if (w_hs)
					nxt_state = st_wresp;
			end
			st_wresp: begin
				if (b_hs)
					nxt_state = st_idle;
			end
			st_rresp: begin
				if (r_hs)
					nxt_state = st_idle;
			end
			st_fault: begin
				nxt_state = st_idle;
			end
			default: begin
				nxt_state = st_fault;	// Unused encodings pass through the fault state.
			end
		endcase
	end

	// In the data state the address comes from the latch, otherwise straight off the bus.
	assign wr_addr   = (state == st_wdata) ? aw_addr_q : bus_i.aw_addr;
	assign wr_sel    = wr_addr[axi_addr_w-1:reg_word_lsb];
	assign wr_mapped = wr_sel < num_digits;

	assign rd_sel_o  = ar_addr_q[axi_addr_w-1:reg_word_lsb];
	assign rd_mapped = rd_sel_o < num_digits;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state    <= st_idle;
			wr_pulse <= 1'b0;
		end else begin
			state    <= nxt_state;
			wr_pulse <= w_hs && wr_mapped && bus_i.w_strb[0];
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			aw_addr_q <= bus_i.aw_addr;
		if (ar_hs)
			ar_addr_q <= bus_i.ar_addr;
		if (w_hs) begin
			cmd_idx  <= wr_sel;
			cmd_data <= bus_i.w_data[$bits(digit_reg_t)-1:0];
			b_resp_q <= wr_mapped ? resp_okay : resp_slverr;
		end
	end

	assign wr_cmd_o = '{wr: wr_pulse, idx: cmd_idx, data: cmd_data};

	a_resp_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(bus_o.b_valid && bus_o.r_valid));

	// A stalled write response keeps both its valid and its code.
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bus_o.b_valid && !bus_i.b_ready |=> bus_o.b_valid && $stable(bus_o.b_resp));

endmodule : seg_axil_slave

// ==== source/seg_collect.sv ====
`timescale 1ns/1ps

module seg_collect (
	input	seg_disp_pkg::digit_reg_t				states_i [seg_disp_pkg::num_digits],
	input	logic [seg_disp_pkg::seg_w-1:0]			segs_i [seg_disp_pkg::num_digits],
	input	logic [seg_disp_pkg::digit_sel_w-1:0]	rd_sel_i,
	output	logic [31:0]							rd_word_o,
	output	logic [seg_disp_pkg::seg_w-1:0]			hex_o [seg_disp_pkg::num_digits]
);

	import seg_disp_pkg::*;

	// Read-back mux. An index past the last digit leaves the word at zero.
	always_comb begin
		rd_word_o = '0;
		for (int i = 0; i < num_digits; i++) begin
			if (rd_sel_i == digit_sel_w'(i))
				rd_word_o[$bits(digit_reg_t)-1:0] = states_i[i];
		end
	end

	always_comb begin
		for (int i = 0; i < num_digits; i++) begin
			hex_o[i] = segs_i[i];
		end
	end

endmodule : seg_collect

// ==== source/seg_digit.sv ====
`timescale 1ns/1ps

module seg_digit #(
	parameter int digit_index = 0
) (
	input	logic								clk,
	input	logic								rst,
	input	seg_disp_pkg::wr_cmd_t				cmd_i,
	output	seg_disp_pkg::digit_reg_t			state_o,
	output	logic [seg_disp_pkg::seg_w-1:0]		seg_o
);

	import seg_disp_pkg::*;

	digit_reg_t	cur;
	logic		hit;

	// Only the cell whose index matches takes the broadcast command.
	assign hit = cmd_i.wr && (cmd_i.idx == digit_sel_w'(digit_index));

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			cur <= '0;	// Shows a "0" after reset.
		else if (hit)
			cur <= cmd_i.data;
	end

	assign state_o = cur;

	always_comb begin
		if (cur.blank)
			seg_o = seg_blank;
		else
			seg_o = glyph_table[cur.value];
	end

	// The slave decodes addresses, so a strobed index must name a real digit.
	a_idx_range: assert property (@(posedge clk) disable iff (rst)
		cmd_i.wr |-> cmd_i.idx < num_digits);

endmodule : seg_digit

// ==== source/seg_disp_pkg.sv ====
package seg_disp_pkg;

	localparam int num_digits  = 6;
	localparam int digit_sel_w = 3;
	localparam int seg_w       = 7;

	// Digit n sits at byte offset 4*n, so the word index starts at address bit 2.
	localparam int reg_word_lsb = 2;

	// Same layout as bits 4:0 of the register word.
	typedef struct packed {
		logic		blank;	// Digit dark when set.
		logic [3:0]	value;
	} digit_reg_t;

	// Write command broadcast to every digit cell.
	typedef struct packed {
		logic						wr;		// One-cycle strobe.
		logic [digit_sel_w-1:0]		idx;
		digit_reg_t					data;
	} wr_cmd_t;

	// Active-low patterns, bit 0 is segment a and bit 6 is segment g.
	localparam logic [seg_w-1:0] glyph_table [16] = '{
		7'b1000000,	// 0
		7'b1111001,	// 1
		7'b0100100,	// 2
		7'b0110000,	// 3
		7'b0011001,	// 4
		7'b0010010,	// 5
		7'b0000010,	// 6
		7'b1111000,	// 7
		7'b0000000,	// 8
		7'b0010000,	// 9
		7'b0001000,	// A
		7'b0000011,	// b
		7'b1000110,	// C
		7'b0100001,	// d
		7'b0000110,	// E
		7'b0001110	// F
	};

	localparam logic [seg_w-1:0] seg_blank = 7'b1111111;

endpackage : seg_disp_pkg

// ==== source/seg_display_top.sv ====
`timescale 1ns/1ps

module seg_display_top (
	input	logic								clk,
	input	logic								rst,
	input	seg_axi_pkg::axil_req_t				axil_i,
	output	seg_axi_pkg::axil_rsp_t				axil_o,
	output	logic [seg_disp_pkg::seg_w-1:0]		hex_o [seg_disp_pkg::num_digits]
);

	import seg_axi_pkg::*;
	import seg_disp_pkg::*;

	wr_cmd_t				wr_cmd;
	logic [digit_sel_w-1:0]	rd_sel;
	logic [axi_data_w-1:0]	rd_word;

	digit_reg_t				dig_state [num_digits];
	logic [seg_w-1:0]		dig_seg [num_digits];

	seg_axil_slave u_slave (
		.clk		(clk),
		.rst		(rst),
		.bus_i		(axil_i),
		.bus_o		(axil_o),
		.wr_cmd_o	(wr_cmd),
		.rd_sel_o	(rd_sel),
		.rd_word_i	(rd_word)
	);

	// One cell per digit, all listening to the same write command.
	for (genvar g = 0; g < num_digits; g++) begin : g_digit
		seg_digit #(
			.digit_index	(g)
		) u_digit (
			.clk		(clk),
			.rst		(rst),
			.cmd_i		(wr_cmd),
			.state_o	(dig_state[g]),
			.seg_o		(dig_seg[g])
		);
	end

	seg_collect u_collect (
		.states_i	(dig_state),
		.segs_i		(dig_seg),
		.rd_sel_i	(rd_sel),
		.rd_word_o	(rd_word),
		.hex_o		(hex_o)
	);

endmodule : seg_display_top
